// ==== chipsetRegister/chipsetRegister.sv ====
/*
 * Chipset register cycle engine
 * Runs 68000-style nAS/nUDS/nLDS cycles in step with the C1/C3
 * phase clocks, splits long accesses into two words, waits on
 * nDBR and steers the chipset data buffers
 */

`timescale 1ns/1ps
`include "u712_config.svh"

module chipsetRegister (
    input  logic       CLK40,
    input  logic       rst,
    input  logic       C1,
    input  logic       C3,
    input  logic       nDBR,
    input  logic       nREGSPACE,
    input  logic       RnW,
    input  logic       SIZ0,
    input  logic       SIZ1,
    input  logic       nAWE,
    input  logic [1:0] A,
    output logic       nAS,
    output logic       nUDS,
    output logic       nLDS,
    output logic       nREGEN,
    output logic       regTa,
    output logic       nVBEN,
    output logic       nDRDEN,
    output logic       DRDDIR
);

    localparam int SyncN = `U712_SYNC_STAGES;

    // Synchronizer chains, newest sample in bit 0
    logic [SyncN-1:0] c1Sync;
    logic [SyncN-1:0] c3Sync;
    logic [SyncN-1:0] dbrSync;

    // Last synchronized phase levels for edge detect
    logic c1Last;
    logic c3Last;

    logic phaseEdge;
    logic busFree;

    u712_pkg::regCycleState_t state;

    // Second word of a long access
    logic wordCnt;
    // First half-phase of the data window seen
    logic halfCnt;

    logic [1:0] siz;
    logic       twoWords;
    logic       byteAccess;

    ////////////////////////////////////////////////////////////////////
    // Phase clock and nDBR synchronizers
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (rst) begin
            c1Sync  <= '0;
            c3Sync  <= '0;
            // Bus free while in reset
            dbrSync <= '1;
            c1Last  <= 1'b0;
            c3Last  <= 1'b0;
        end else begin
            c1Sync  <= {c1Sync[SyncN-2:0], C1};
            c3Sync  <= {c3Sync[SyncN-2:0], C3};
            dbrSync <= {dbrSync[SyncN-2:0], nDBR};
            c1Last  <= c1Sync[SyncN-1];
            c3Last  <= c3Sync[SyncN-1];
        end
    end

    // Any change of C1 or C3 is one half-phase edge
    assign phaseEdge = (c1Sync[SyncN-1] != c1Last) || (c3Sync[SyncN-1] != c3Last);

    // nDBR high means the chipset has let go
    assign busFree = dbrSync[SyncN-1];

    ////////////////////////////////////////////////////////////////////
    // Access decode
    ////////////////////////////////////////////////////////////////////

    assign siz        = {SIZ1, SIZ0};
    assign byteAccess = (siz == `U712_SIZ_BYTE);

    // Chipset bus is 16 bits wide
    assign twoWords = (siz == `U712_SIZ_LONG) || (siz == `U712_SIZ_LINE);

    ////////////////////////////////////////////////////////////////////
    // Register cycle FSM
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (rst) begin
            state   <= u712_pkg::IDLE;
            nAS     <= 1'b1;
            nUDS    <= 1'b1;
            nLDS    <= 1'b1;
            nREGEN  <= 1'b1;
            wordCnt <= 1'b0;
            halfCnt <= 1'b0;
        end else begin
            case (state)
                u712_pkg::IDLE: begin
                    wordCnt <= 1'b0;
                    if (!nREGSPACE) begin
                        state <= u712_pkg::WAITBUS;
                    end
                end

                u712_pkg::WAITBUS: begin
                    // Stall here for as long as the chipset wants
                    if (busFree) begin
                        state <= u712_pkg::ADDR;
                    end
                end

                u712_pkg::ADDR: begin
                    if (!busFree) begin
                        // Bus taken back before nAS went out
                        state <= u712_pkg::WAITBUS;
                    end else if (phaseEdge) begin
                        nAS    <= 1'b0;
                        nREGEN <= 1'b0;
                        state  <= u712_pkg::STROBE;
                    end
                end

                u712_pkg::STROBE: begin
                    if (phaseEdge) begin
                        // Byte: upper strobe for even, lower for odd
                        nUDS    <= byteAccess && A[0];
                        nLDS    <= byteAccess && !A[0];
                        halfCnt <= 1'b0;
                        state   <= u712_pkg::DATA;
                    end
                end

                u712_pkg::DATA: begin
                    if (phaseEdge) begin
                        if (!halfCnt) begin
                            halfCnt <= 1'b1;
                        end else begin
                            // End of this word
                            nAS  <= 1'b1;
                            nUDS <= 1'b1;
                            nLDS <= 1'b1;
                            if (twoWords && !wordCnt) begin
                                wordCnt <= 1'b1;
                                state   <= u712_pkg::WAITBUS;
                            end else begin
                                nREGEN <= 1'b1;
                                state  <= u712_pkg::ACK;
                            end
                        end
                    end
                end

                u712_pkg::ACK: begin
                    // Single cycle, regTa decoded from it
                    state <= u712_pkg::RELEASE;
                end

                u712_pkg::RELEASE: begin
                    // CPU drops nREGSPACE once it sees nTA
                    if (nREGSPACE) begin
                        state <= u712_pkg::IDLE;
                    end
                end

                default: begin
                    state <= u712_pkg::IDLE;
                end
            endcase
        end
    end

    assign regTa = (state == u712_pkg::ACK);

    ////////////////////////////////////////////////////////////////////
    // Data buffer steering
    ////////////////////////////////////////////////////////////////////

    // Video side buffer tracks the register window
    assign nVBEN = nREGEN;

    // Open while we own the bus, or whenever the chipset writes
    assign nDRDEN = !((!nREGEN && busFree) || !nAWE);

    // Toward the CPU only for register reads
    assign DRDDIR = !nREGEN && RnW;

endmodule

// ==== common/u712_config.svh ====
/*
 * U712 build constants
 * Synchronizer depth and the 68040 SIZ encodings
 */

`ifndef U712_CONFIG_SVH
`define U712_CONFIG_SVH

// Flops between the chipset phase clocks and the CLK40 domain
// Also used for nDBR
`define U712_SYNC_STAGES 2

// 68040 transfer size codes on {SIZ1, SIZ0}
`define U712_SIZ_LONG 2'b00
`define U712_SIZ_BYTE 2'b01
`define U712_SIZ_WORD 2'b10

// Line transfers reach register space as plain long words
`define U712_SIZ_LINE 2'b11

`endif

// ==== common/u712_pkg.sv ====
/*
 * U712 shared types
 * Register cycle states of the chipset bridge and the
 * active-low byte-lane vector seen by the CPU side
 */

package u712_pkg;

    // Chipset register cycle sequence
    // Long and line accesses pass WAITBUS..DATA twice
    typedef enum logic [2:0] {
        // No request, waiting for nREGSPACE
        IDLE    = 3'd0,
        // Chipset holding the bus via nDBR
        WAITBUS = 3'd1,
        // Waiting for the edge that drops nAS
        ADDR    = 3'd2,
        // Waiting for the edge that drops the data strobes
        STROBE  = 3'd3,
        // Strobes active for two half-phase edges
        DATA    = 3'd4,
        // One CLK40 cycle of completion
        ACK     = 3'd5,
        // CPU still holds nREGSPACE low
        RELEASE = 3'd6
    } regCycleState_t;

    // Active-low byte enables
    // Bit 3 is the upper byte (A=0), bit 0 the lowest (A=3)
    typedef logic [3:0] byteLanes_t;

endpackage

// ==== logic/byteEnable.sv ====
/*
 * CPU byte-lane decode
 * Turns RnW, SIZ and the low address bits into the four
 * active-low byte enables of the 32-bit CPU data bus
 */

`timescale 1ns/1ps
`include "u712_config.svh"

module byteEnable (
    input  logic                 RnW,
    input  logic                 SIZ0,
    input  logic                 SIZ1,
    input  logic [1:0]           A,
    output u712_pkg::byteLanes_t lanes
);

    // Size code as one field
    logic [1:0] siz;

    assign siz = {SIZ1, SIZ0};

    ////////////////////////////////////////////////////////////////////
    // Lane table
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        // Reads drive every lane, the CPU picks its bytes
        lanes = 4'b0000;
        if (!RnW) begin
            case (siz)
                `U712_SIZ_BYTE: begin
                    // Single lane picked by the offset
                    case (A)
                        2'd0:    lanes = 4'b0111;
                        2'd1:    lanes = 4'b1011;
                        2'd2:    lanes = 4'b1101;
                        default: lanes = 4'b1110;
                    endcase
                end
                `U712_SIZ_WORD: begin
                    // Upper or lower half by A1
                    if (A[1]) begin
                        lanes = 4'b1100;
                    end else begin
                        lanes = 4'b0011;
                    end
                end
                `U712_SIZ_LONG: begin
                    lanes = 4'b0000;
                end
                `U712_SIZ_LINE: begin
                    // Same as long in register space
                    lanes = 4'b0000;
                end
                default: begin
                    lanes = 4'b0000;
                end
            endcase
        end
    end

endmodule

// ==== logic/transferAck.sv ====
/*
 * 68040 transfer acknowledge
 * Registers the register-cycle completion pulse into a
 * single-cycle active-low nTA
 */

`timescale 1ns/1ps

module transferAck (
    input  logic CLK40,
    input  logic rst,
    input  logic regTa,
    input  logic nREGSPACE,
    output logic nTA
);

    // Request still pending on the CPU side
    logic reqLive;
    // Acknowledge wanted this cycle
    logic ackNext;

    assign reqLive = !nREGSPACE;

    // Never two low cycles in a row
    assign ackNext = regTa && reqLive && nTA;

    ////////////////////////////////////////////////////////////////////
    // nTA register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (rst) begin
            nTA <= 1'b1;
        end else begin
            // Withdrawn requests get no acknowledge
            nTA <= !ackNext;
        end
    end

endmodule

// ==== logic/u712Top.sv ====
/*
 * U712 register bridge top
 * CPU byte enables, chipset register cycle engine and
 * 68040 transfer acknowledge
 */

`timescale 1ns/1ps

module u712Top (
    input  logic       CLK40,
    input  logic       rst,
    input  logic       RnW,
    input  logic       SIZ0,
    input  logic       SIZ1,
    input  logic [1:0] A,
    input  logic       nREGSPACE,
    input  logic       C1,
    input  logic       C3,
    input  logic       nDBR,
    input  logic       nAWE,
    output logic       nUUBE,
    output logic       nUMBE,
    output logic       nLMBE,
    output logic       nLLBE,
    output logic       nAS,
    output logic       nUDS,
    output logic       nLDS,
    output logic       nREGEN,
    output logic       nTA,
    output logic       nVBEN,
    output logic       nDRDEN,
    output logic       DRDDIR
);

    u712_pkg::byteLanes_t lanes;
    logic                 regTa;

    ////////////////////////////////////////////////////////////////////
    // CPU byte enables
    ////////////////////////////////////////////////////////////////////

    byteEnable uByteEnable (
        .RnW   (RnW),
        .SIZ0  (SIZ0),
        .SIZ1  (SIZ1),
        .A     (A),
        .lanes (lanes)
    );

    // Upper byte on bit 3
    assign nUUBE = lanes[3];
    assign nUMBE = lanes[2];
    assign nLMBE = lanes[1];
    assign nLLBE = lanes[0];

    ////////////////////////////////////////////////////////////////////
    // Chipset register cycles and buffers
    ////////////////////////////////////////////////////////////////////

    chipsetRegister uChipsetRegister (
        .CLK40     (CLK40),
        .rst       (rst),
        .C1        (C1),
        .C3        (C3),
        .nDBR      (nDBR),
        .nREGSPACE (nREGSPACE),
        .RnW       (RnW),
        .SIZ0      (SIZ0),
        .SIZ1      (SIZ1),
        .nAWE      (nAWE),
        .A         (A),
        .nAS       (nAS),
        .nUDS      (nUDS),
        .nLDS      (nLDS),
        .nREGEN    (nREGEN),
        .regTa     (regTa),
        .nVBEN     (nVBEN),
        .nDRDEN    (nDRDEN),
        .DRDDIR    (DRDDIR)
    );

    // CPU acknowledge
    transferAck uTransferAck (
        .CLK40     (CLK40),
        .rst       (rst),
        .regTa     (regTa),
        .nREGSPACE (nREGSPACE),
        .nTA       (nTA)
    );

endmodule

// ==== project.f ====
+incdir+common
common/u712_pkg.sv
logic/byteEnable.sv
chipsetRegister/chipsetRegister.sv
logic/transferAck.sv
logic/u712Top.sv
test/u712_chk.sv
test/u712_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the U712 testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module u712_tb -f project.f -o u712_sim
# Assertion failures stop the run, the log decides
./obj_dir/u712_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "SIMULATION PASSED" sim.log; then
    echo "Run passed"
else
    echo "Run failed"
    exit 1
fi

// ==== test/u712_chk.sv ====
/*
 * U712 bus protocol checker
 * Concurrent assertions on the 68000-style strobes, nTA width
 * and nDBR hold, bound to the bridge top level
 */

`timescale 1ns/1ps

module u712_chk (
    input logic CLK40,
    input logic rst,
    input logic nAS,
    input logic nUDS,
    input logic nLDS,
    input logic nTA,
    input logic nDBR
);

    //////////////////////////////////////////////////////////////////////
    // Strobe ordering
    //////////////////////////////////////////////////////////////////////

    // Data strobes only inside an address strobe
    assert property (@(posedge CLK40) disable iff (rst)
        (!nUDS || !nLDS) |-> !nAS)
        else $error("data strobe active while nAS is high");

    //////////////////////////////////////////////////////////////////////
    // CPU acknowledge and chipset hold
    //////////////////////////////////////////////////////////////////////

    // Single-cycle nTA
    assert property (@(posedge CLK40) disable iff (rst)
        !nTA |=> nTA)
        else $error("nTA low for two cycles in a row");

    // No new address strobe while the chipset owns the bus
    assert property (@(posedge CLK40) disable iff (rst)
        $fell(nAS) |-> nDBR)
        else $error("nAS fell while nDBR was low");

endmodule

// ==== test/u712_tb.sv ====
/*
 * U712 register bridge testbench
 * Drives CPU register requests through a stimulus table against a
 * modelled C1/C3 phase clock and nDBR hold, and checks byte lanes,
 * strobes, word splitting, nTA and buffer steering
 */

`timescale 1ns/1ps

module u712_tb;

    // 12 rows x 2 words x 200 cycles, plus reset
    localparam int TimeoutCycles = 12 * 2 * 200 + 3;

    // Row fields, MSB first
    // RnW | SIZ1,SIZ0 | A1,A0 | lanes UU,UM,LM,LL | {nUDS,nLDS} when active | words
    localparam logic [12:0] StimTable [12] = '{
        13'b0_01_00_0111_01_01,   // write byte A=0
        13'b0_01_01_1011_10_01,   // write byte A=1
        13'b0_01_10_1101_01_01,   // write byte A=2
        13'b0_01_11_1110_10_01,   // write byte A=3
        13'b0_10_00_0011_00_01,   // write word A=0
        13'b0_10_10_1100_00_01,   // write word A=2
        13'b0_00_00_0000_00_10,   // write long
        13'b0_11_00_0000_00_10,   // write line
        13'b1_01_01_0000_10_01,   // read byte A=1
        13'b1_10_10_0000_00_01,   // read word A=2
        13'b1_00_00_0000_00_10,   // read long
        13'b1_01_10_0000_01_01    // read byte A=2
    };

    logic       CLK40;
    logic       rst;
    logic       RnW;
    logic       SIZ0;
    logic       SIZ1;
    logic [1:0] A;
    logic       nREGSPACE;
    logic       C1;
    logic       C3;
    logic       nDBR;
    logic       nAWE;
    logic       nUUBE;
    logic       nUMBE;
    logic       nLMBE;
    logic       nLLBE;
    logic       nAS;
    logic       nUDS;
    logic       nLDS;
    logic       nREGEN;
    logic       nTA;
    logic       nVBEN;
    logic       nDRDEN;
    logic       DRDDIR;

    int          valueErrors;
    int          protocolErrors;
    int          cycleCount;
    int          phaseCnt;
    logic [31:0] lfsrState;

    u712Top dut (.*);

    // Bus protocol assertions on the DUT top
    bind u712Top u712_chk chk (
        .CLK40 (CLK40),
        .rst   (rst),
        .nAS   (nAS),
        .nUDS  (nUDS),
        .nLDS  (nLDS),
        .nTA   (nTA),
        .nDBR  (nDBR)
    );

    //////////////////////////////////////////////////////////////////////
    // Clocks
    //////////////////////////////////////////////////////////////////////

    initial begin
        CLK40 = 1'b0;
        forever #20 CLK40 = ~CLK40;
    end

    // C1/C3 quadrature, 28 CLK40 cycles, C3 a quarter behind
    initial begin
        phaseCnt = 0;
        C1 = 1'b1;
        C3 = 1'b0;
        forever begin
            @(negedge CLK40);
            phaseCnt = (phaseCnt + 1) % 28;
            C1 = (phaseCnt < 14);
            C3 = (((phaseCnt + 21) % 28) < 14);
        end
    end

    // Watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge CLK40);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, a register cycle never finished", cycleCount);
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    task automatic takeBits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    task automatic reportValue(input string name, input int got, input int exp);
        $display("ERR %s got %0h exp %0h at %0t", name, got, exp, $time);
        valueErrors++;
    endtask

    task automatic reportEvent(input string msg);
        $display("%s at %0t", msg, $time);
        protocolErrors++;
    endtask

    // Idle bus levels, out of reset or between rows
    task automatic checkIdle();
        if (nAS != 1'b1) reportValue("nAS", int'(nAS), 1);
        if (nUDS != 1'b1) reportValue("nUDS", int'(nUDS), 1);
        if (nLDS != 1'b1) reportValue("nLDS", int'(nLDS), 1);
        if (nREGEN != 1'b1) reportValue("nREGEN", int'(nREGEN), 1);
        if (nTA != 1'b1) reportValue("nTA", int'(nTA), 1);
        if (nVBEN != 1'b1) reportValue("nVBEN", int'(nVBEN), 1);
        if (nDRDEN != 1'b1) reportValue("nDRDEN", int'(nDRDEN), 1);
        if (DRDDIR != 1'b0) reportValue("DRDDIR", int'(DRDDIR), 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // One table row, sampled then driven at each falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic runRow(input int idx);
        logic [12:0] row;
        int          hold;
        int          ticks;
        int          nasFalls;
        int          taLows;
        logic        prevNas;
        logic        strobeSeen;
        logic        done;
        row = StimTable[idx];
        takeBits(5, hold);
        // Chipset grabs the bus first, let the synchronizer settle
        if (hold > 0) begin
            nDBR = 1'b0;
            repeat (3) @(negedge CLK40);
        end
        RnW = row[12];
        {SIZ1, SIZ0} = row[11:10];
        A = row[9:8];
        nREGSPACE = 1'b0;
        ticks = 0;
        nasFalls = 0;
        taLows = 0;
        prevNas = 1'b1;
        strobeSeen = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge CLK40);
            ticks++;
            if (ticks == 1 && {nUUBE, nUMBE, nLMBE, nLLBE} != row[7:4]) begin
                reportValue("lanes", int'({nUUBE, nUMBE, nLMBE, nLLBE}), int'(row[7:4]));
            end
            if (prevNas && !nAS) begin
                nasFalls++;
                strobeSeen = 1'b0;
            end
            if (!nAS && (!nUDS || !nLDS)) begin
                strobeSeen = 1'b1;
                if ({nUDS, nLDS} != row[3:2]) begin
                    reportValue("nUDS,nLDS", int'({nUDS, nLDS}), int'(row[3:2]));
                end
            end
            if (!prevNas && nAS && !strobeSeen) begin
                reportEvent("nAS period ended without any data strobe");
            end
            // Data path open while nAS is out
            if (!nAS) begin
                if (nREGEN != 1'b0) reportValue("nREGEN", int'(nREGEN), 0);
                if (nVBEN != 1'b0) reportValue("nVBEN", int'(nVBEN), 0);
                if (DRDDIR != row[12]) reportValue("DRDDIR", int'(DRDDIR), int'(row[12]));
                if (nDRDEN != 1'b0) reportValue("nDRDEN", int'(nDRDEN), 0);
            end
            // Bus held by the chipset
            if (!nDBR) begin
                if (nAS != 1'b1) reportValue("nAS", int'(nAS), 1);
                if (nDRDEN != 1'b1) reportValue("nDRDEN", int'(nDRDEN), 1);
            end
            prevNas = nAS;
            if (!nTA) begin
                taLows++;
                nREGSPACE = 1'b1;
                done = 1'b1;
            end
            if (!nDBR && ticks >= hold) begin
                nDBR = 1'b1;
            end
        end
        if (nasFalls != int'(row[1:0])) reportValue("nAS count", nasFalls, int'(row[1:0]));
        // nTA must not repeat once the request is gone
        repeat (4) begin
            @(negedge CLK40);
            if (!nTA) taLows++;
        end
        if (taLows != 1) reportValue("nTA low cycles", taLows, 1);
        checkIdle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int errorTotal;
        int idx;
        valueErrors = 0;
        protocolErrors = 0;
        lfsrState = 32'h1ecd_b611;
        rst = 1'b1;
        RnW = 1'b1;
        SIZ0 = 1'b0;
        SIZ1 = 1'b0;
        A = 2'b00;
        nREGSPACE = 1'b1;
        nDBR = 1'b1;
        nAWE = 1'b1;
        repeat (3) @(negedge CLK40);
        checkIdle();
        rst = 1'b0;
        @(negedge CLK40);
        checkIdle();
        for (idx = 0; idx < 12; idx++) begin
            runRow(idx);
        end
        // Chipset write strobe opens the buffer on its own
        nAWE = 1'b0;
        @(negedge CLK40);
        if (nDRDEN != 1'b0) reportValue("nDRDEN", int'(nDRDEN), 0);
        nAWE = 1'b1;
        @(negedge CLK40);
        errorTotal = valueErrors + protocolErrors;
        $display("Error counts: %0d value, %0d protocol, %0d total",
                 valueErrors, protocolErrors, errorTotal);
        if (errorTotal == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
